//--- Makefile
# Verilator build and run of the mips core testbench
# the run target fails when the testbench stops with $fatal

SIM = obj_dir/VmipsCoreTb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --top-module mipsCoreTb -f mipsExt.f

run: compile
	./$(SIM)

clean:
	rm -rf obj_dir

//--- bench/mipsCoreTb.sv
//********************
// testbench for the single-cycle mips core
// runs the program from the data file and checks every store against it
//********************
module mipsCoreTb;

  logic        clk;
  logic        reset;
  logic [31:0] pc;
  logic [31:0] instr;      // fetched word as the core decodes it
  logic        memWrite;
  logic [31:0] aluOut;     // data address
  logic [31:0] writeData;
  logic [31:0] readData;

  logic [31:0] testdata [256];  // length, program, store count, expected pairs
  logic [31:0] instrMem [64];
  logic [31:0] dataMem  [64];

  int progLen;     // program words
  int storeCount;  // expected stores
  int expectBase;  // index of the first expected address
  int storeIdx;    // stores checked so far
  int cycleCount;  // cycles since reset release
  int cycleLimit;

  mipsCore dut (
    .clk       (clk),
    .reset     (reset),
    .pc        (pc),
    .instr     (instr),
    .memWrite  (memWrite),
    .aluOut    (aluOut),
    .writeData (writeData),
    .readData  (readData)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // both memories answer within the cycle
  assign instr    = instrMem[pc[7:2]];       // word index
  assign readData = dataMem[aluOut[7:2]];

  // data memory write port that refills during reset
  always @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 64; i++) begin
        dataMem[6'(i)] <= 32'hd00d0000 + (i << 2);  // byte address in low half
      end
    end else if (memWrite) begin
      dataMem[aluOut[7:2]] <= writeData;
    end
  end

  // compares one observed value with its expected value
  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected) begin
      $display("** Error: %s is %h, expected %h", name, actual, expected);
      $display("Result: FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // store monitor and cycle counter
  always @(posedge clk) begin
    if (reset) begin
      storeIdx   = 0;
      cycleCount = 0;
    end else begin
      if (cycleCount == 0) checkValue("pc after reset", pc, 32'h0);  // first fetch
      cycleCount++;
      if (memWrite) begin
        checkValue($sformatf("aluOut of store %0d", storeIdx), aluOut,
                   testdata[8'(expectBase + 2 * storeIdx)]);
        checkValue($sformatf("writeData of store %0d", storeIdx), writeData,
                   testdata[8'(expectBase + 2 * storeIdx + 1)]);
        storeIdx++;  // wakes the main sequence on the last one
      end
    end
  end

  initial begin
    reset <= 1'b1;
    $readmemh("bench/mipsTestdata.hex", testdata);
    progLen = int'(testdata[0]);

    if (progLen < 1 || progLen > 64) begin
      $display("the program length in the data file is out of range");
      $display("Result: FAILED");
      $fatal(1, "bad data file");
    end

    storeCount = int'(testdata[8'(progLen + 1)]);
    expectBase = progLen + 2;

    if (storeCount < 1 || expectBase + 2 * storeCount > 256) begin
      $display("the store count in the data file is out of range");
      $display("Result: FAILED");
      $fatal(1, "bad data file");
    end

    for (int i = 0; i < 64; i++) begin
      if (i < progLen) instrMem[6'(i)] = testdata[8'(i + 1)];
      else instrMem[6'(i)] = 32'h0;  // sll $0 filler
    end

    cycleLimit = 4 * progLen + 20;  // generous for a straight program with a few jumps

    repeat (4) @(posedge clk);
    reset <= 1'b0;

    wait (storeIdx == storeCount || cycleCount >= cycleLimit);
    if (storeIdx == storeCount) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("after %0d cycles the program had made %0d of %0d expected stores",
               cycleCount, storeIdx, storeCount);
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
  end

endmodule

//--- bench/mipsTestdata.hex
// first word is the program length, then the program words, then the store count,
// then one expected pair per store, data address followed by store data
0000002e
// sw at address 0, lui and ori constant, addi -5
ac000000 3c011234 34218678 ac010004 2002fffb ac020008
// addi 0x0f0f, add and sub with stores
20030f0f 00232020 ac04000c 00622822 ac050010
// and, or, xor with stores
00233024 ac060014 00233825 ac070018 00234026 ac08001c
// slt $2,$3 then sltu $2,$3 and $3,$2 and $3,$3
0043482a ac090020 0043502b ac0a0024 0062582b ac0b0028 0063602b ac0c002c
// sll by 0, 1 and 31
00016800 ac0d0030 00017040 ac0e0034 00027fc0 ac0f0038
// sw, lw of the same word, store it again
ac040064 8c100064 ac100068
// beq not taken, beq taken over a marker, bne not taken
10620001 ac03006c 10630001 ac020070 14630001 ac050070
// bne taken over a marker, j over a marker, last store, jump to itself
14620001 ac020074 0800002c ac020074 ac060074 0800002d
// store count
00000014
00000000 00000000  00000004 12348678
00000008 fffffffb  0000000c 12349587
00000010 00000f14  00000014 00000608
00000018 12348f7f  0000001c 12348977
00000020 00000001  00000024 00000000
00000028 00000001  0000002c 00000000
00000030 12348678  00000034 24690cf0
00000038 80000000  00000064 12349587
00000068 12349587  0000006c 00000f0f
00000070 00000f14  00000074 00000608

//--- hw/controlUnit.sv
//********************
// main decoder of the core, opcode and funct to the control struct
// unknown codes come out as a no-op
//********************
module controlUnit (
  input  mipsPkg::instrWord   instr,
  output mipsPkg::ctrlSignals ctrl
);
  import mipsPkg::*;

  logic [5:0] op;     // shared by all three views
  logic [5:0] funct;  // only meaningful for r-type

  assign op    = instr.rView.op;
  assign funct = instr.rView.funct;

  always_comb begin
    ctrl           = '0;       // nothing written, no branch
    ctrl.aluCtrl   = aluAdd;
    ctrl.resultSel = resAlu;
    case (op)
      opRtype: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst   = 1'b1;  // destination in rd
        case (funct)
          fnAdd:  ctrl.aluCtrl = aluAdd;
          fnSub:  ctrl.aluCtrl = aluSub;
          fnAnd:  ctrl.aluCtrl = aluAnd;
          fnOr:   ctrl.aluCtrl = aluOr;
          fnXor:  ctrl.aluCtrl = aluXor;
          fnSlt:  ctrl.aluCtrl = aluSlt;
          fnSltu: ctrl.resultSel = resSltu;  // comparator bit
          fnSll:  ctrl.resultSel = resSll;   // shifter output
          default: begin
            ctrl.regWrite = 1'b0;  // unsupported funct
            ctrl.regDst   = 1'b0;
          end
        endcase
      end
      opLw: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;  // base plus offset
        ctrl.memToReg = 1'b1;
      end
      opSw: begin
        ctrl.aluSrc   = 1'b1;
        ctrl.memWrite = 1'b1;
      end
      opBeq: begin
        ctrl.branch  = 1'b1;
        ctrl.aluCtrl = aluSub;  // zero when rs equals rt
      end
      opBne: begin
        ctrl.branch   = 1'b1;
        ctrl.branchNe = 1'b1;
        ctrl.aluCtrl  = aluSub;
      end
      opAddi: begin
        ctrl.regWrite = 1'b1;
        ctrl.aluSrc   = 1'b1;  // sign-extended immediate
      end
      opJ: ctrl.jump = 1'b1;
      opOri: begin
        ctrl.regWrite   = 1'b1;
        ctrl.aluSrc     = 1'b1;
        ctrl.zeroExtImm = 1'b1;  // upper half stays clear
        ctrl.aluCtrl    = aluOr;
      end
      opLui: begin
        ctrl.regWrite  = 1'b1;    // writes rt
        ctrl.resultSel = resLui;  // alu value unused
      end
      default: ;  // unknown opcode stays a no-op
    endcase
  end

  // a store never writes the register file in the same cycle
  always_comb begin
    assert (!(ctrl.regWrite && ctrl.memWrite))
      else $error("register write and memory write decoded together");
  end

endmodule

//--- hw/executeUnit.sv
//********************
// execute stage of the core, alu plus shifter, lui and unsigned compare
// drives the data address, the zero flag and the writeback result
//********************
module executeUnit (
  input  mipsPkg::instrWord             instr,
  input  mipsPkg::ctrlSignals           ctrl,
  input  logic [mipsPkg::dataWidth-1:0] srcA,
  input  logic [mipsPkg::dataWidth-1:0] rtData,
  output logic [mipsPkg::dataWidth-1:0] aluOut,
  output logic                          zero,
  output logic [mipsPkg::dataWidth-1:0] result
);
  import mipsPkg::*;

  logic [dataWidth-1:0] extImm;     // immediate widened to a word
  logic [dataWidth-1:0] srcB;
  logic [dataWidth-1:0] sllValue;
  logic [dataWidth-1:0] luiValue;
  logic [dataWidth-1:0] sltuValue;
  logic                 less;       // unsigned srcA < srcB

  always_comb begin
    if (ctrl.zeroExtImm) extImm = {{(dataWidth-16){1'b0}}, instr.iView.imm};
    else extImm = {{(dataWidth-16){instr.iView.imm[15]}}, instr.iView.imm};
  end

  assign srcB = ctrl.aluSrc ? extImm : rtData;

  always_comb begin
    case (ctrl.aluCtrl)
      aluAnd:  aluOut = srcA & srcB;
      aluOr:   aluOut = srcA | srcB;
      aluAdd:  aluOut = srcA + srcB;  // also load and store address
      aluXor:  aluOut = srcA ^ srcB;
      aluSub:  aluOut = srcA - srcB;  // beq and bne compare here
      aluSlt:  aluOut = dataWidth'($signed(srcA) < $signed(srcB));
      default: aluOut = '0;
    endcase
  end

  assign zero = (aluOut == '0);

  unsignedCompare sltuCmp (
    .a    (srcA),
    .b    (srcB),
    .less (less)
  );

  assign sltuValue = {{(dataWidth-1){1'b0}}, less};
  assign sllValue  = rtData << instr.rView.shamt;          // zeros shift in
  assign luiValue  = {instr.iView.imm, {(dataWidth-16){1'b0}}};

  always_comb begin
    case (ctrl.resultSel)
      resSltu: result = sltuValue;
      resLui:  result = luiValue;
      resSll:  result = sllValue;
      default: result = aluOut;  // resAlu
    endcase
  end

endmodule

//--- hw/mipsCore.sv
//********************
// top of the single-cycle mips core
// instruction and data memories connect outside on plain combinational buses
//********************
module mipsCore (
  input  logic                          clk,
  input  logic                          reset,
  output logic [mipsPkg::dataWidth-1:0] pc,
  input  mipsPkg::instrWord             instr,
  output logic                          memWrite,
  output logic [mipsPkg::dataWidth-1:0] aluOut,
  output logic [mipsPkg::dataWidth-1:0] writeData,
  input  logic [mipsPkg::dataWidth-1:0] readData
);
  import mipsPkg::*;

  ctrlSignals           ctrl;    // decoded from the current word
  logic [dataWidth-1:0] srcA;    // rs operand
  logic [dataWidth-1:0] result;  // execute value for writeback
  logic                 zero;

  controlUnit ctrlDec (
    .instr (instr),
    .ctrl  (ctrl)
  );

  nextPcLogic pcUnit (
    .clk   (clk),
    .reset (reset),
    .instr (instr),
    .ctrl  (ctrl),
    .zero  (zero),
    .pc    (pc)
  );

  registerFile regFile (
    .clk      (clk),
    .instr    (instr),
    .ctrl     (ctrl),
    .result   (result),
    .readData (readData),
    .srcA     (srcA),
    .rtData   (writeData)  // store data leaves the core
  );

  executeUnit exec (
    .instr  (instr),
    .ctrl   (ctrl),
    .srcA   (srcA),
    .rtData (writeData),
    .aluOut (aluOut),
    .zero   (zero),
    .result (result)
  );

  assign memWrite = ctrl.memWrite;

endmodule

//--- hw/mipsPkg.sv
//********************
// shared widths, instruction codes and types of the single-cycle mips core
// every core module imports it inside its body
//********************
package mipsPkg;

  localparam int dataWidth    = 32;  // machine word
  localparam int regAddrWidth = 5;   // register index

  // opcode field, top six bits of the word
  localparam logic [5:0] opRtype = 6'b000000;
  localparam logic [5:0] opLw    = 6'b100011;
  localparam logic [5:0] opSw    = 6'b101011;
  localparam logic [5:0] opBeq   = 6'b000100;
  localparam logic [5:0] opBne   = 6'b000101;
  localparam logic [5:0] opAddi  = 6'b001000;
  localparam logic [5:0] opJ     = 6'b000010;
  localparam logic [5:0] opOri   = 6'b001101;
  localparam logic [5:0] opLui   = 6'b001111;

  // funct field of r-type words
  localparam logic [5:0] fnAdd  = 6'b100000;
  localparam logic [5:0] fnSub  = 6'b100010;
  localparam logic [5:0] fnAnd  = 6'b100100;
  localparam logic [5:0] fnOr   = 6'b100101;
  localparam logic [5:0] fnXor  = 6'b100110;
  localparam logic [5:0] fnSlt  = 6'b101010;
  localparam logic [5:0] fnSltu = 6'b101011;
  localparam logic [5:0] fnSll  = 6'b000000;

  localparam logic [2:0] aluAnd = 3'b000;
  localparam logic [2:0] aluOr  = 3'b001;
  localparam logic [2:0] aluAdd = 3'b010;
  localparam logic [2:0] aluXor = 3'b011;
  localparam logic [2:0] aluSub = 3'b110;  // also the branch compare
  localparam logic [2:0] aluSlt = 3'b111;

  // which execute value becomes the written result
  localparam logic [1:0] resAlu  = 2'b00;
  localparam logic [1:0] resSltu = 2'b01;
  localparam logic [1:0] resLui  = 2'b10;
  localparam logic [1:0] resSll  = 2'b11;

  typedef struct packed {
    logic [5:0]              op;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] rd;
    logic [4:0]              shamt;  // sll amount
    logic [5:0]              funct;
  } rFields;

  typedef struct packed {
    logic [5:0]              op;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    logic [15:0]             imm;
  } iFields;

  typedef struct packed {
    logic [5:0]  op;
    logic [25:0] target;  // word index inside the 256 MB region
  } jFields;

  // one fetched word read three ways
  typedef union packed {
    rFields rView;
    iFields iView;
    jFields jView;
  } instrWord;

  typedef struct packed {
    logic       regWrite;
    logic       regDst;      // 1 writes rd, 0 writes rt
    logic       aluSrc;      // 1 takes the immediate
    logic       branch;
    logic       branchNe;    // inverts the zero test
    logic       memWrite;
    logic       memToReg;    // 1 writes the loaded word
    logic       jump;
    logic       zeroExtImm;  // ori immediate
    logic [2:0] aluCtrl;
    logic [1:0] resultSel;
  } ctrlSignals;

endpackage

//--- hw/nextPcLogic.sv
//********************
// program counter and next-address selection
// sequential, branch and jump targets, jump wins over branch
//********************
module nextPcLogic (
  input  logic                          clk,
  input  logic                          reset,
  input  mipsPkg::instrWord             instr,
  input  mipsPkg::ctrlSignals           ctrl,
  input  logic                          zero,
  output logic [mipsPkg::dataWidth-1:0] pc
);
  import mipsPkg::*;

  logic [dataWidth-1:0] pcPlus4;       // sequential address
  logic [dataWidth-1:0] branchOffset;  // sign-extended, word scaled
  logic [dataWidth-1:0] pcBranch;
  logic [dataWidth-1:0] pcJump;
  logic [dataWidth-1:0] pcNext;
  logic                 takeBranch;

  assign pcPlus4      = pc + dataWidth'(4);
  assign branchOffset = {{(dataWidth-18){instr.iView.imm[15]}}, instr.iView.imm, 2'b00};
  assign pcBranch     = pcPlus4 + branchOffset;
  assign pcJump       = {pcPlus4[dataWidth-1 -: 4], instr.jView.target, 2'b00};

  assign takeBranch = ctrl.branch & (zero == ~ctrl.branchNe);  // beq on zero, bne on nonzero

  always_comb begin
    if (ctrl.jump) pcNext = pcJump;
    else if (takeBranch) pcNext = pcBranch;
    else pcNext = pcPlus4;
  end

  always_ff @(posedge clk) begin
    if (reset) pc <= '0;  // fetch starts at address 0
    else pc <= pcNext;
  end

  // every target is built from word offsets
  assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
    else $error("pc lost word alignment: %h", pc);

endmodule

//--- hw/registerFile.sv
//********************
// 32-entry register file with two read ports and one write port
// destination and writeback value are chosen here from the control struct
//********************
module registerFile (
  input  logic                          clk,
  input  mipsPkg::instrWord             instr,
  input  mipsPkg::ctrlSignals           ctrl,
  input  logic [mipsPkg::dataWidth-1:0] result,
  input  logic [mipsPkg::dataWidth-1:0] readData,
  output logic [mipsPkg::dataWidth-1:0] srcA,
  output logic [mipsPkg::dataWidth-1:0] rtData
);
  import mipsPkg::*;

  logic [dataWidth-1:0]    regs [2**regAddrWidth];
  logic [regAddrWidth-1:0] rs;
  logic [regAddrWidth-1:0] rt;
  logic [regAddrWidth-1:0] writeReg;
  logic [dataWidth-1:0]    writeValue;

  assign rs = instr.rView.rs;
  assign rt = instr.rView.rt;

  assign writeReg   = ctrl.regDst ? instr.rView.rd : rt;  // r-type uses rd
  assign writeValue = ctrl.memToReg ? readData : result;  // load or execute value

  always_ff @(posedge clk) begin
    if (ctrl.regWrite && writeReg != '0) regs[writeReg] <= writeValue;
  end

  // register 0 is hardwired
  assign srcA   = (rs == '0) ? '0 : regs[rs];
  assign rtData = (rt == '0) ? '0 : regs[rt];

  // holds even after a write aimed at register 0
  assert property (@(posedge clk)
    ((rs != '0) || (srcA == '0)) && ((rt != '0) || (rtData == '0)))
    else $error("register 0 read back nonzero");

endmodule

//--- hw/unsignedCompare.sv
//********************
// unsigned less-than for sltu
// finds the top differing bit with a priority encoder
//********************
module unsignedCompare (
  input  logic [mipsPkg::dataWidth-1:0] a,
  input  logic [mipsPkg::dataWidth-1:0] b,
  output logic                          less
);
  import mipsPkg::*;

  logic [dataWidth-1:0]         diff;      // bits where a and b disagree
  logic [$clog2(dataWidth)-1:0] msbIndex;  // highest disagreeing bit
  logic                         anyDiff;   // clear when a equals b

  assign diff = a ^ b;

  // ascending scan, so the last hit is the most significant one
  always_comb begin
    msbIndex = '0;
    anyDiff  = 1'b0;
    for (int i = 0; i < dataWidth; i++) begin
      if (diff[i]) begin
        msbIndex = i[$clog2(dataWidth)-1:0];
        anyDiff  = 1'b1;
      end
    end
  end

  // a is smaller when it holds the 0 at that bit
  assign less = anyDiff & ~a[msbIndex];

endmodule

//--- mipsExt.f
hw/mipsPkg.sv
hw/unsignedCompare.sv
hw/controlUnit.sv
hw/nextPcLogic.sv
hw/registerFile.sv
hw/executeUnit.sv
hw/mipsCore.sv
bench/mipsCoreTb.sv
